/* hdl/pool_max_pkg.sv */
`default_nettype none

package pool_max_pkg;

	// ************************************************************************
	// Data format and lane count.
	// ************************************************************************
	localparam int DATA_WIDTH = 16;
	localparam int EXP_WIDTH = 5;
	localparam int MANT_WIDTH = 10;
	localparam int POOL_PARA_Y = 3;

	// ************************************************************************
	// Window geometry.
	// ************************************************************************
	localparam int POOL_SIZE_WIDTH = 2;
	localparam int MAX_POOL_SIZE = 3;
	localparam int WINDOW_COUNT_WIDTH = $clog2(MAX_POOL_SIZE * MAX_POOL_SIZE + 1);

	localparam logic [DATA_WIDTH-1:0] FP16_CANON_NAN = 16'h7e00; // Positive quiet NaN.

	typedef logic [DATA_WIDTH-1:0] fp16_t;
	typedef logic [POOL_PARA_Y*DATA_WIDTH-1:0] lane_bus_t; // Lane 0 sits in the low bits.
	typedef logic [POOL_SIZE_WIDTH-1:0] pool_size_t;
	typedef logic [WINDOW_COUNT_WIDTH-1:0] window_count_t;

	typedef enum logic {
		IDLE,
		IN_WINDOW
	} seq_state_t;

endpackage

`default_nettype wire

/* hdl/fp16_max_compare.sv */
`timescale 1ns/1ps
`default_nettype none

module fp16_max_compare (
	input  pool_max_pkg::fp16_t a,
	input  pool_max_pkg::fp16_t b,
	output pool_max_pkg::fp16_t max_value
);

	localparam int MAG_WIDTH = pool_max_pkg::DATA_WIDTH - 1;
	localparam int MSB = pool_max_pkg::DATA_WIDTH - 1;

	logic a_sign;
	logic b_sign;
	logic [MAG_WIDTH-1:0] a_mag;
	logic [MAG_WIDTH-1:0] b_mag;
	logic a_nan;
	logic b_nan;
	logic both_zero;

	assign a_sign = a[MSB];
	assign b_sign = b[MSB];
	assign a_mag = a[MAG_WIDTH-1:0];
	assign b_mag = b[MAG_WIDTH-1:0];

	// NaN has an all-ones exponent and a nonzero mantissa.
	assign a_nan = (&a[MSB-1 -: pool_max_pkg::EXP_WIDTH])
		&& (|a[pool_max_pkg::MANT_WIDTH-1:0]);
	assign b_nan = (&b[MSB-1 -: pool_max_pkg::EXP_WIDTH])
		&& (|b[pool_max_pkg::MANT_WIDTH-1:0]);

	assign both_zero = (a_mag == '0) && (b_mag == '0); // +0 and -0 compare equal.

	always_comb begin
		if (a_nan || b_nan) begin
			max_value = pool_max_pkg::FP16_CANON_NAN;
		end else if (a_sign != b_sign) begin
			if (both_zero || !a_sign) begin
				max_value = a; // Ties keep a.
			end else begin
				max_value = b;
			end
		end else if (!a_sign) begin
			max_value = (b_mag > a_mag) ? b : a;
		end else begin
			max_value = (b_mag < a_mag) ? b : a; // Smaller magnitude wins among negatives.
		end
	end

endmodule

`default_nettype wire

/* hdl/max_pool_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module max_pool_unit (
	input  logic clk,
	input  logic reset,
	input  logic sample_valid,
	input  logic first_sample,
	input  logic last_sample,
	input  pool_max_pkg::fp16_t sample,
	output pool_max_pkg::fp16_t result,
	output logic result_valid
);

	pool_max_pkg::fp16_t running_max;
	pool_max_pkg::fp16_t cmp_a;
	pool_max_pkg::fp16_t next_max;

	// ************************************************************************
	// On the opening sample the comparator sees the sample against itself.
	// That loads it directly and still maps a NaN to the canonical one.
	// ************************************************************************
	assign cmp_a = first_sample ? sample : running_max;

	fp16_max_compare u_compare (
		.a         (cmp_a),
		.b         (sample),
		.max_value (next_max)
	);

	always_ff @(posedge clk) begin
		if (sample_valid) begin
			running_max <= next_max;
		end
	end

	// ************************************************************************
	// Lane result, held until the next window closes.
	// ************************************************************************
	always_ff @(posedge clk) begin
		if (reset) begin
			result <= '0;
			result_valid <= 1'b0;
		end else begin
			result_valid <= sample_valid && last_sample; // One-cycle pulse.
			if (sample_valid && last_sample) begin
				result <= next_max;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/pool_window_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module pool_window_sequencer (
	input  logic clk,
	input  logic reset,
	input  logic in_valid,
	input  pool_max_pkg::lane_bus_t in_data,
	input  pool_max_pkg::pool_size_t pool_size,
	output logic sample_valid,
	output logic first_sample,
	output logic last_sample,
	output pool_max_pkg::lane_bus_t sample_data
);

	pool_max_pkg::seq_state_t state;
	pool_max_pkg::pool_size_t pool_side;
	pool_max_pkg::window_count_t new_window_len;
	pool_max_pkg::window_count_t window_len;
	pool_max_pkg::window_count_t sample_count;
	pool_max_pkg::window_count_t next_count;

	// A pool size of 0 runs as 1.
	assign pool_side = (pool_size == '0) ? pool_max_pkg::pool_size_t'(1) : pool_size;
	assign new_window_len = pool_max_pkg::window_count_t'(pool_side)
		* pool_max_pkg::window_count_t'(pool_side);
	assign next_count = sample_count + pool_max_pkg::window_count_t'(1);

	always_ff @(posedge clk) begin
		sample_data <= in_data; // Sample bus lines up with the control flags.
	end

	// ************************************************************************
	// Window FSM.
	// ************************************************************************
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= pool_max_pkg::IDLE;
			window_len <= '0;
			sample_count <= '0;
			sample_valid <= 1'b0;
			first_sample <= 1'b0;
			last_sample <= 1'b0;
		end else begin
			sample_valid <= in_valid;
			first_sample <= 1'b0;
			last_sample <= 1'b0;
			case (state)
				pool_max_pkg::IDLE: begin
					if (in_valid) begin
						window_len <= new_window_len; // Size is fixed for the whole window.
						sample_count <= pool_max_pkg::window_count_t'(1);
						first_sample <= 1'b1;
						if (new_window_len == pool_max_pkg::window_count_t'(1)) begin
							last_sample <= 1'b1;
						end else begin
							state <= pool_max_pkg::IN_WINDOW;
						end
					end
				end
				pool_max_pkg::IN_WINDOW: begin
					if (in_valid) begin
						sample_count <= next_count;
						if (next_count == window_len) begin
							last_sample <= 1'b1;
							state <= pool_max_pkg::IDLE;
						end
					end
				end
				default: begin
					state <= pool_max_pkg::IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/pool_max_para.sv */
`timescale 1ns/1ps
`default_nettype none

module pool_max_para (
	input  logic clk,
	input  logic reset,
	input  logic in_valid,
	input  pool_max_pkg::lane_bus_t in_data,
	input  pool_max_pkg::pool_size_t pool_size,
	output logic out_valid,
	output pool_max_pkg::lane_bus_t out_data
);

	localparam int DW = pool_max_pkg::DATA_WIDTH;

	logic sample_valid;
	logic first_sample;
	logic last_sample;
	pool_max_pkg::lane_bus_t sample_data;
	logic [pool_max_pkg::POOL_PARA_Y-1:0] lane_valid;

	// ************************************************************************
	// Shared window control.
	// ************************************************************************
	pool_window_sequencer u_sequencer (
		.clk          (clk),
		.reset        (reset),
		.in_valid     (in_valid),
		.in_data      (in_data),
		.pool_size    (pool_size),
		.sample_valid (sample_valid),
		.first_sample (first_sample),
		.last_sample  (last_sample),
		.sample_data  (sample_data)
	);

	// ************************************************************************
	// Lanes.
	// ************************************************************************
	generate
		genvar i;
		for (i = 0; i < pool_max_pkg::POOL_PARA_Y; i = i + 1) begin : g_lane
			max_pool_unit u_lane (
				.clk          (clk),
				.reset        (reset),
				.sample_valid (sample_valid),
				.first_sample (first_sample),
				.last_sample  (last_sample),
				.sample       (sample_data[i*DW +: DW]),
				.result       (out_data[i*DW +: DW]),
				.result_valid (lane_valid[i])
			);
		end
	endgenerate

	assign out_valid = lane_valid[0]; // All lanes share control, so their valids agree.

endmodule

`default_nettype wire

/* sim/pool_max_ref.svh */
`ifndef POOL_MAX_REF_SVH
`define POOL_MAX_REF_SVH

// One step of a 32-bit xorshift generator.
function automatic logic [31:0] xorshift32(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

function automatic bit fp16_is_nan(input pool_max_pkg::fp16_t v);
	return (v[14:10] == 5'h1f) && (v[9:0] != 10'h000);
endfunction

// ****************************************************************************
// Maps a float16 that is not a NaN onto an unsigned key with the same order.
// ****************************************************************************
function automatic logic [15:0] fp16_order_key(input pool_max_pkg::fp16_t v);
	if (v[14:0] == 15'h0000) begin
		return 16'h8000; // Both zeros share one key.
	end else if (v[15]) begin
		return {1'b0, ~v[14:0]}; // Larger magnitude sorts lower.
	end else begin
		return {1'b1, v[14:0]};
	end
endfunction

// Folds one sample into the window maximum of a lane.
function automatic pool_max_pkg::fp16_t window_max_step(input pool_max_pkg::fp16_t acc,
	input pool_max_pkg::fp16_t s, input bit first);
	if (fp16_is_nan(s) || (!first && fp16_is_nan(acc))) begin
		return pool_max_pkg::FP16_CANON_NAN;
	end else if (first) begin
		return s;
	end else if (fp16_order_key(s) > fp16_order_key(acc)) begin
		return s;
	end else begin
		return acc; // Equal keys keep the earlier sample.
	end
endfunction

`endif

/* sim/pool_max_para_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module pool_max_para_tb;

	localparam int DW = pool_max_pkg::DATA_WIDTH;
	localparam int LANES = pool_max_pkg::POOL_PARA_Y;
	localparam int MAX_GAP = 4;
	localparam int RANDOM_WINDOWS = 40;
	localparam int GAP_WINDOWS = 30;
	localparam int SPECIAL_WINDOWS = 6;
	localparam int NAN_WINDOWS = 3;
	// Every window counted at the largest size of 9 samples.
	localparam int MAX_STROBES = (2 + RANDOM_WINDOWS + GAP_WINDOWS + SPECIAL_WINDOWS + 1
		+ NAN_WINDOWS + 2) * 9;
	localparam int TIMEOUT_CYCLES = MAX_STROBES * MAX_GAP + 20;

	logic clk;
	logic reset;
	logic in_valid;
	pool_max_pkg::lane_bus_t in_data;
	pool_max_pkg::pool_size_t pool_size;
	logic out_valid;
	pool_max_pkg::lane_bus_t out_data;

	int cycle_count;
	logic [31:0] rng_state;
	pool_max_pkg::fp16_t special_vals [0:9];
	pool_max_pkg::lane_bus_t win_data [0:8];
	pool_max_pkg::lane_bus_t expected_q [$];
	int last_cycle_q [$];
	pool_max_pkg::lane_bus_t held_data;

	`include "pool_max_ref.svh"

	pool_max_para UUT (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.in_data   (in_data),
		.pool_size (pool_size),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
	end

	// ************************************************************************
	// Helpers.
	// ************************************************************************
	function automatic logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic pool_max_pkg::fp16_t random_sample();
		pool_max_pkg::fp16_t v;
		v = pool_max_pkg::fp16_t'(next_rand() >> 8);
		if (&v[14:10]) v[14] = 1'b0; // Keeps plain random data finite.
		return v;
	endfunction

	task automatic fill_random_window();
		int k;
		int lane;
		for (k = 0; k < 9; k++) begin
			for (lane = 0; lane < LANES; lane++) win_data[k][lane*DW +: DW] = random_sample();
		end
	endtask

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("test failed");
		$fatal(1, "Stopped on the first error at cycle %0d.", cycle_count);
	endtask

	task automatic check_fp16(input int lane, input pool_max_pkg::fp16_t expected,
		input pool_max_pkg::fp16_t actual);
		if (actual !== expected) begin
			fail_run($sformatf("MISMATCH out_data lane %0d: expected %h, actual %h",
				lane, expected, actual));
		end
	endtask

	// Sends win_data[0..len-1] as one window and queues the expected lane maxima.
	task automatic send_window(input pool_max_pkg::pool_size_t size, input int max_gap);
		int side;
		int len;
		int k;
		int lane;
		int gap;
		pool_max_pkg::fp16_t acc;
		pool_max_pkg::lane_bus_t expected;
		side = (size == 0) ? 1 : int'(size);
		len = side * side;
		for (lane = 0; lane < LANES; lane++) begin
			acc = '0;
			for (k = 0; k < len; k++) begin
				acc = window_max_step(acc, win_data[k][lane*DW +: DW], k == 0);
			end
			expected[lane*DW +: DW] = acc;
		end
		for (k = 0; k < len; k++) begin
			gap = (max_gap > 0 && k > 0) ? next_rand() % (max_gap + 1) : 0;
			repeat (gap) begin
				in_data = pool_max_pkg::lane_bus_t'({next_rand(), next_rand()});
				@(negedge clk);
			end
			in_valid = 1'b1;
			in_data = win_data[k];
			pool_size = (k == 0) ? size : pool_max_pkg::pool_size_t'(next_rand()); // Ignored.
			if (k == len - 1) begin
				expected_q.push_back(expected);
				last_cycle_q.push_back(cycle_count);
			end
			@(negedge clk);
			in_valid = 1'b0;
		end
	endtask

	// ************************************************************************
	// Result checking.
	// ************************************************************************
	always @(negedge clk) begin : compare_results
		pool_max_pkg::lane_bus_t expected;
		int last_cycle;
		int lane;
		if (out_valid === 1'b1) begin
			if (expected_q.size() == 0) begin
				fail_run("ERROR: out_valid was raised with no window pending.");
			end else begin
				expected = expected_q.pop_front();
				last_cycle = last_cycle_q.pop_front();
				if (cycle_count != last_cycle + 2) begin
					fail_run($sformatf("ERROR: out_valid came at cycle %0d instead of cycle %0d.",
						cycle_count, last_cycle + 2));
				end else begin
					for (lane = 0; lane < LANES; lane++) begin
						check_fp16(lane, expected[lane*DW +: DW], out_data[lane*DW +: DW]);
					end
					held_data = expected;
				end
			end
		end else if (out_valid !== 1'b0) begin
			fail_run("ERROR: out_valid is unknown.");
		end else if (last_cycle_q.size() != 0 && cycle_count > last_cycle_q[0] + 2) begin
			fail_run("ERROR: out_valid did not come for a finished window.");
		end else if (reset === 1'b1) begin
			held_data = '0; // Reset clears the lane results.
		end else begin
			for (lane = 0; lane < LANES; lane++) begin
				check_fp16(lane, held_data[lane*DW +: DW], out_data[lane*DW +: DW]);
			end
		end
	end

	always @(posedge clk) begin
		if (cycle_count >= TIMEOUT_CYCLES) begin
			fail_run($sformatf("ERROR: the run did not end within %0d cycles.", TIMEOUT_CYCLES));
		end
	end

	// ************************************************************************
	// Stimulus.
	// ************************************************************************
	initial begin : stimulus
		int w;
		int k;
		int lane;
		rng_state = 32'h5d09;
		cycle_count = 0;
		reset = 1'b1;
		in_valid = 1'b0;
		in_data = '0;
		pool_size = '0;
		special_vals = '{16'hfc00, 16'hfbff, 16'hc000, 16'h8001, 16'h8000,
			16'h0000, 16'h0001, 16'h03ff, 16'h3c00, 16'h7c00};
		repeat (4) @(negedge clk);
		reset = 1'b0;
		repeat (10) @(negedge clk); // Any out_valid here is caught by the checker.

		win_data[0] = {16'h3c00, 16'hc200, 16'h3800};
		win_data[1] = {16'h4200, 16'hc000, 16'h3a00};
		win_data[2] = {16'h3e00, 16'hbc00, 16'h4400};
		win_data[3] = {16'h4000, 16'hc400, 16'h3c00};
		win_data[4] = {16'h3400, 16'hbe00, 16'h4100};
		win_data[5] = {16'h4500, 16'hc100, 16'h3000};
		win_data[6] = {16'h3c00, 16'hc300, 16'h4080};
		win_data[7] = {16'h4100, 16'hbd00, 16'h2c00};
		win_data[8] = {16'h3a00, 16'hc080, 16'h3f00};
		send_window(2'd3, 0);
		win_data[0] = {16'h5640, 16'h0000, 16'hd000};
		win_data[1] = {16'h5200, 16'h8000, 16'hcc00};
		win_data[2] = {16'h5a00, 16'h3c00, 16'hd200};
		win_data[3] = {16'h4c00, 16'hbc00, 16'hce00};
		send_window(2'd2, 0);

		for (w = 0; w < RANDOM_WINDOWS; w++) begin
			fill_random_window();
			send_window(pool_max_pkg::pool_size_t'(next_rand()), 0);
		end
		for (w = 0; w < GAP_WINDOWS; w++) begin
			fill_random_window();
			send_window(pool_max_pkg::pool_size_t'(next_rand()), MAX_GAP);
		end

		for (w = 0; w < SPECIAL_WINDOWS; w++) begin
			for (k = 0; k < 9; k++) begin
				for (lane = 0; lane < LANES; lane++) begin
					win_data[k][lane*DW +: DW] = special_vals[next_rand() % 10];
				end
			end
			send_window(pool_max_pkg::pool_size_t'(next_rand() % 3 + 1), 0);
		end
		for (k = 0; k < 9; k++) begin
			for (lane = 0; lane < LANES; lane++) begin
				win_data[k][lane*DW +: DW] = next_rand() % 2 ? 16'h8000 : 16'h0000;
			end
		end
		for (lane = 0; lane < LANES; lane++) begin
			win_data[0][lane*DW +: DW] = (lane % 2) ? 16'h8000 : 16'h0000;
			win_data[8][lane*DW +: DW] = (lane % 2) ? 16'h0000 : 16'h8000;
		end
		send_window(2'd3, 0); // Only zeros, so the first one seen must come out.

		for (w = 0; w < NAN_WINDOWS; w++) begin
			fill_random_window();
			win_data[next_rand() % 9][(w % LANES)*DW +: DW] =
				{next_rand() % 2 == 1, 5'h1f, 10'(next_rand()) | 10'h001};
			send_window(2'd3, 0);
		end

		while (expected_q.size() != 0) @(negedge clk);
		fill_random_window();
		for (k = 0; k < 4; k++) begin
			in_valid = 1'b1;
			in_data = win_data[k];
			pool_size = 2'd3;
			@(negedge clk);
			in_valid = 1'b0;
		end
		reset = 1'b1; // Drops the open window.
		repeat (2) @(negedge clk);
		reset = 1'b0;
		repeat (5) @(negedge clk);
		fill_random_window();
		send_window(2'd2, 0);

		for (k = 0; k < 10 && expected_q.size() != 0; k++) @(negedge clk);
		if (expected_q.size() == 0) begin
			$display("test passed");
			$finish;
		end else begin
			fail_run("ERROR: windows were still waiting for a result at the end.");
		end
	end

endmodule

`default_nettype wire

/* pool_max_para.f */
+incdir+sim
hdl/pool_max_pkg.sv
hdl/fp16_max_compare.sv
hdl/max_pool_unit.sv
hdl/pool_window_sequencer.sv
hdl/pool_max_para.sv
sim/pool_max_para_tb.sv
